//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_axil_bram
RTL_TOP    := axil_bram_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing
PASS_MSG   := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- axil_bram_top.sv
`timescale 1ns/10ps
`default_nettype none

// AXI4-Lite slave over a 2 KiB block RAM
module axil_bram_top (
    input  logic                                clk,
    input  logic                                arst_n,
    // Write address
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axil_mem_pkg::AXI_ADDR_W-1:0] awaddr,
    // Write data
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [axil_mem_pkg::DATA_W-1:0]     wdata,
    input  logic [axil_mem_pkg::STRB_W-1:0]     wstrb,
    // Write response
    output logic                                bvalid,
    input  logic                                bready,
    output axil_mem_pkg::resp_e                 bresp,
    // Read address
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [axil_mem_pkg::AXI_ADDR_W-1:0] araddr,
    // Read data
    output logic                                rvalid,
    input  logic                                rready,
    output logic [axil_mem_pkg::DATA_W-1:0]     rdata,
    output axil_mem_pkg::resp_e                 rresp
);

    logic [axil_mem_pkg::WORD_ADDR_W-1:0] ram_addr;
    logic [axil_mem_pkg::DATA_W-1:0]      ram_din;
    logic [axil_mem_pkg::STRB_W-1:0]      ram_we;
    logic [axil_mem_pkg::DATA_W-1:0]      ram_dout;

    mem_req_if wr_req ();
    mem_req_if rd_req ();

    axil_write_ctrl u_write_ctrl (
        .clk, .arst_n,
        .awvalid, .awready, .awaddr,
        .wvalid, .wready, .wdata, .wstrb,
        .bvalid, .bready, .bresp,
        .mem (wr_req.requester)
    );

    axil_read_ctrl u_read_ctrl (
        .clk, .arst_n,
        .arvalid, .arready, .araddr,
        .rvalid, .rready, .rdata, .rresp,
        .mem (rd_req.requester)
    );

    bram_port_arbiter u_arbiter (
        .clk, .arst_n,
        .wr (wr_req.arbiter),
        .rd (rd_req.arbiter),
        .ram_addr, .ram_din, .ram_we, .ram_dout
    );

    bram #(
        .DEPTH (axil_mem_pkg::MEM_DEPTH),
        .WIDTH (axil_mem_pkg::DATA_W)
    ) u_ram (
        .clk,
        .addr (ram_addr),
        .din  (ram_din),
        .we   (ram_we),
        .dout (ram_dout)
    );

endmodule

`default_nettype wire

//--- axil_mem_pkg.sv
`default_nettype none

package axil_mem_pkg;

    // Bus and memory geometry
    localparam int AXI_ADDR_W  = 12;            // 4 KiB byte address space
    localparam int DATA_W      = 32;
    localparam int STRB_W      = DATA_W / 8;    // Byte lanes per word
    localparam int MEM_DEPTH   = 512;           // 2 KiB of words
    localparam int WORD_ADDR_W = $clog2(MEM_DEPTH);

    // Lowest byte address outside the RAM, upper half of the map
    localparam logic [AXI_ADDR_W-1:0] MEM_BYTES = AXI_ADDR_W'(MEM_DEPTH * STRB_W);

    // AXI response codes, EXOKAY and DECERR never produced
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

    // Channel controller phase
    typedef enum logic [1:0] {
        IDLE      = 2'd0,   // Waiting for an address
        ACCESS    = 2'd1,   // Request raised, waiting for grant
        WAIT_DATA = 2'd2,   // Read only, RAM output valid this cycle
        RESPOND   = 2'd3    // Response presented on B or R
    } chan_state_e;

    // Which requester wins the next contended cycle
    typedef enum logic {
        OWN_WR = 1'b0,
        OWN_RD = 1'b1
    } owner_e;

endpackage

`default_nettype wire

//--- axil_read_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// AXI4-Lite read channel, one transaction at a time
module axil_read_ctrl (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [axil_mem_pkg::AXI_ADDR_W-1:0] araddr,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [axil_mem_pkg::DATA_W-1:0]     rdata,
    output axil_mem_pkg::resp_e                 rresp,
    mem_req_if.requester                        mem
);

    axil_mem_pkg::chan_state_e state, state_nxt;

    logic                                 accept;
    logic                                 in_range;
    logic [axil_mem_pkg::WORD_ADDR_W-1:0] addr_q;
    logic [axil_mem_pkg::DATA_W-1:0]      data_q;   // Held while R stalls
    axil_mem_pkg::resp_e                  resp_q;

    assign accept   = (state == axil_mem_pkg::IDLE) && arvalid;
    assign in_range = araddr < axil_mem_pkg::MEM_BYTES;
    assign arready  = accept;

    always_comb begin
        state_nxt = state;
        unique case (state)
            axil_mem_pkg::IDLE:
                if (accept)
                    state_nxt = in_range ? axil_mem_pkg::ACCESS : axil_mem_pkg::RESPOND;
            axil_mem_pkg::ACCESS:
                if (mem.gnt) state_nxt = axil_mem_pkg::WAIT_DATA;
            axil_mem_pkg::WAIT_DATA:
                state_nxt = axil_mem_pkg::RESPOND;       // RAM output captured here
            axil_mem_pkg::RESPOND:
                if (rready) state_nxt = axil_mem_pkg::IDLE;
            default: state_nxt = axil_mem_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= axil_mem_pkg::IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= araddr[axil_mem_pkg::WORD_ADDR_W+1:2];
            resp_q <= in_range ? axil_mem_pkg::OKAY : axil_mem_pkg::SLVERR;
            if (!in_range)
                data_q <= '0;                             // Out of range reads as zero
        end else if (state == axil_mem_pkg::WAIT_DATA) begin
            data_q <= mem.rdata;
        end
    end

    // Read side never writes
    assign mem.req   = (state == axil_mem_pkg::ACCESS);
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign mem.wstrb = '0;

    assign rvalid = (state == axil_mem_pkg::RESPOND);
    assign rdata  = data_q;
    assign rresp  = resp_q;

endmodule

`default_nettype wire

//--- axil_write_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// AXI4-Lite write channel, one transaction at a time
module axil_write_ctrl (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [axil_mem_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [axil_mem_pkg::DATA_W-1:0]     wdata,
    input  logic [axil_mem_pkg::STRB_W-1:0]     wstrb,
    output logic                                bvalid,
    input  logic                                bready,
    output axil_mem_pkg::resp_e                 bresp,
    mem_req_if.requester                        mem
);

    axil_mem_pkg::chan_state_e state, state_nxt;

    logic                                 accept;    // AW and W taken together
    logic                                 in_range;
    logic [axil_mem_pkg::WORD_ADDR_W-1:0] addr_q;
    logic [axil_mem_pkg::DATA_W-1:0]      data_q;
    logic [axil_mem_pkg::STRB_W-1:0]      strb_q;
    axil_mem_pkg::resp_e                  resp_q;

    assign accept   = (state == axil_mem_pkg::IDLE) && awvalid && wvalid;
    assign in_range = awaddr < axil_mem_pkg::MEM_BYTES;

    // Both channels handshake on the same cycle
    assign awready = accept;
    assign wready  = accept;

    always_comb begin
        state_nxt = state;
        unique case (state)
            axil_mem_pkg::IDLE:
                if (accept)
                    state_nxt = in_range ? axil_mem_pkg::ACCESS : axil_mem_pkg::RESPOND;
            axil_mem_pkg::ACCESS:
                if (mem.gnt) state_nxt = axil_mem_pkg::RESPOND;  // RAM written this cycle
            axil_mem_pkg::RESPOND:
                if (bready) state_nxt = axil_mem_pkg::IDLE;
            default: state_nxt = axil_mem_pkg::IDLE;             // WAIT_DATA unused here
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= axil_mem_pkg::IDLE;
        else
            state <= state_nxt;
    end

    // Payload captured on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= awaddr[axil_mem_pkg::WORD_ADDR_W+1:2];  // Drop byte offset
            data_q <= wdata;
            strb_q <= wstrb;
            resp_q <= in_range ? axil_mem_pkg::OKAY : axil_mem_pkg::SLVERR;
        end
    end

    assign mem.req   = (state == axil_mem_pkg::ACCESS);
    assign mem.addr  = addr_q;
    assign mem.wdata = data_q;
    assign mem.wstrb = strb_q;

    assign bvalid = (state == axil_mem_pkg::RESPOND);
    assign bresp  = resp_q;

endmodule

`default_nettype wire

//--- bram.sv
`timescale 1ns/10ps
`default_nettype none

// Single port RAM, byte lane writes, one cycle registered read
module bram #(
    parameter int DEPTH = axil_mem_pkg::MEM_DEPTH,
    parameter int WIDTH = axil_mem_pkg::DATA_W
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    input  logic [WIDTH/8-1:0]       we,     // One enable per byte lane
    output logic [WIDTH-1:0]         dout
);

    localparam int NUM_BYTES = WIDTH / 8;

    logic [WIDTH-1:0] ram [DEPTH];
    logic [WIDTH-1:0] dout_q;

    // Read first, old word comes out on a same cycle write
    always_ff @(posedge clk) begin
        dout_q <= ram[addr];
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (we[i])
                ram[addr][i*8 +: 8] <= din[i*8 +: 8];  // Only enabled lanes change
        end
    end

    assign dout = dout_q;

endmodule

`default_nettype wire

//--- bram_port_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

// Shares the single RAM port between the write and read controllers
module bram_port_arbiter (
    input  logic                                 clk,
    input  logic                                 arst_n,
    mem_req_if.arbiter                           wr,
    mem_req_if.arbiter                           rd,
    output logic [axil_mem_pkg::WORD_ADDR_W-1:0] ram_addr,
    output logic [axil_mem_pkg::DATA_W-1:0]      ram_din,
    output logic [axil_mem_pkg::STRB_W-1:0]      ram_we,
    input  logic [axil_mem_pkg::DATA_W-1:0]      ram_dout
);

    axil_mem_pkg::owner_e owner;

    logic contend;   // Both sides asking this cycle
    logic gnt_wr;
    logic gnt_rd;

    assign contend = wr.req && rd.req;

    // Lone requester always wins, owner breaks ties
    assign gnt_wr = wr.req && (!rd.req || owner == axil_mem_pkg::OWN_WR);
    assign gnt_rd = rd.req && (!wr.req || owner == axil_mem_pkg::OWN_RD);

    assign wr.gnt = gnt_wr;
    assign rd.gnt = gnt_rd;

    // Priority passes to the loser after a tie
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            owner <= axil_mem_pkg::OWN_WR;
        else if (contend)
            owner <= (owner == axil_mem_pkg::OWN_WR) ? axil_mem_pkg::OWN_RD
                                                     : axil_mem_pkg::OWN_WR;
    end

    assign ram_addr = gnt_wr ? wr.addr : rd.addr;
    assign ram_din  = wr.wdata;                   // Only the write side carries data
    assign ram_we   = gnt_wr ? wr.wstrb : '0;     // Idle and read grants leave memory alone

    assign rd.rdata = ram_dout;
    assign wr.rdata = '0;

endmodule

`default_nettype wire

//--- compile.f
axil_mem_pkg.sv
mem_req_if.sv
bram.sv
axil_write_ctrl.sv
axil_read_ctrl.sv
bram_port_arbiter.sv
axil_bram_top.sv
tb_axil_bram.sv

//--- mem_req_if.sv
`timescale 1ns/10ps
`default_nettype none

// One requester to the RAM port arbiter
interface mem_req_if;

    logic                                 req;    // Held until gnt seen
    logic                                 gnt;    // Combinational from arbiter
    logic [axil_mem_pkg::WORD_ADDR_W-1:0] addr;   // Word address
    logic [axil_mem_pkg::DATA_W-1:0]      wdata;
    logic [axil_mem_pkg::STRB_W-1:0]      wstrb;
    logic [axil_mem_pkg::DATA_W-1:0]      rdata;  // Valid the cycle after gnt

    modport requester (
        output req, addr, wdata, wstrb,
        input  gnt, rdata
    );

    modport arbiter (
        input  req, addr, wdata, wstrb,
        output gnt, rdata
    );

endinterface

`default_nettype wire

//--- tb_axil_bram.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axil_bram;

    localparam int FILL_WORDS  = 32;                                // Test window of words 0..31
    localparam int RAND_EACH   = 75;                                // Random writes and as many reads
    localparam int NUM_WRITES  = FILL_WORDS + 6 + RAND_EACH;
    localparam int NUM_READS   = 4 + RAND_EACH;
    localparam int TIMEOUT_CYC = 40 * (NUM_WRITES + NUM_READS) + 100;
    localparam int MEM_BYTES   = axil_mem_pkg::MEM_DEPTH * axil_mem_pkg::STRB_W;

    logic                clk;
    logic                arst_n;
    logic                awvalid, awready, wvalid, wready, bvalid, bready;
    logic                arvalid, arready, rvalid, rready;
    logic [11:0]         awaddr, araddr;
    logic [31:0]         wdata, rdata;
    logic [3:0]          wstrb;
    axil_mem_pkg::resp_e bresp, rresp;

    logic [31:0]         shadow [axil_mem_pkg::MEM_DEPTH];   // Expected RAM contents
    logic [31:0]         rng_state = 32'd47;
    bit                  wr_busy = 1'b0;                     // A write owns wr_word
    logic [9:0]          wr_word;
    logic [11:0]         wr_exp_addr;
    logic [31:0]         wr_exp_data, rd_exp_data;
    logic [3:0]          wr_exp_strb;
    axil_mem_pkg::resp_e rd_exp_resp;
    bit                  stall_en;                           // Random B and R back-pressure
    int                  cycles = 0;

    axil_bram_top DUT (.*);

    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Word window 0..31 with one in eight landing in the upper half
    function automatic logic [11:0] pick_addr();
        logic [31:0] r;
        r = next_random();
        return {(r[2:0] == 3'd0), 4'b0000, r[12:8], 2'b00};
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int i = 0; i < 4; i++)
            if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];     // Strobed lanes only
        return res;
    endfunction

    // Memory model where the upper half reads zero with SLVERR
    function automatic logic [31:0] ref_read(input logic [11:0] addr,
                                             output axil_mem_pkg::resp_e resp);
        if (int'(addr) < MEM_BYTES) begin
            resp = axil_mem_pkg::OKAY;
            return shadow[addr[10:2]];
        end
        resp = axil_mem_pkg::SLVERR;
        return 32'h0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic write_txn(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        bit done;
        @(posedge clk);
        wr_busy     = 1'b1;                                  // Claim on the edge before reads pick
        wr_word     = addr[11:2];
        wr_exp_addr = addr;
        wr_exp_data = data;
        wr_exp_strb = strb;
        #1;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        @(negedge clk);
        while (!awready) @(negedge clk);                     // AW and W go together
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        done    = 1'b0;
        while (!done) begin
            bready = stall_en ? (next_random() % 4 != 0) : 1'b1;
            @(negedge clk);
            done = bvalid && bready;
            if (done) wr_busy = 1'b0;                        // RAM already written
            @(posedge clk);
            #1;
        end
        bready = 1'b0;
    endtask

    task automatic read_txn(input logic [11:0] fixed_addr, input bit random_pick);
        logic [11:0] addr;
        bit          done;
        @(posedge clk);
        #1;
        addr = fixed_addr;
        if (random_pick) begin
            addr = pick_addr();
            while (wr_busy && addr[11:2] == wr_word)         // Skip a word still being written
                addr = pick_addr();
        end
        arvalid = 1'b1;
        araddr  = addr;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        done    = 1'b0;
        while (!done) begin
            rready = stall_en ? (next_random() % 4 != 0) : 1'b1;
            @(negedge clk);
            done = rvalid && rready;
            @(posedge clk);
            #1;
        end
        rready = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Timeout: transactions still pending after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $fatal(1, "run limit reached");
        end
    end

    // Sampled mid-cycle so a handshake seen here completes on the next edge
    always @(negedge clk) begin : compare
        axil_mem_pkg::resp_e exp_resp;
        if (arst_n) begin
            if (bvalid && bready) begin
                exp_resp = (int'(wr_exp_addr) < MEM_BYTES) ? axil_mem_pkg::OKAY
                                                           : axil_mem_pkg::SLVERR;
                check_value("bresp", 32'(bresp), 32'(exp_resp));
                if (exp_resp == axil_mem_pkg::OKAY)
                    shadow[wr_exp_addr[10:2]] = merge_lanes(shadow[wr_exp_addr[10:2]],
                                                            wr_exp_data, wr_exp_strb);
            end
            if (arvalid && arready)
                rd_exp_data = ref_read(araddr, rd_exp_resp);  // Completed writes only
            if (rvalid && rready) begin
                check_value("rdata", rdata, rd_exp_data);
                check_value("rresp", 32'(rresp), 32'(rd_exp_resp));
            end
        end
    end

    initial begin
        logic [11:0] a;
        arst_n   = 1'b1;
        awvalid  = 1'b0;
        awaddr   = '0;
        wvalid   = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        bready   = 1'b0;
        arvalid  = 1'b0;
        araddr   = '0;
        rready   = 1'b0;
        stall_en = 1'b0;
        #1 arst_n = 1'b0;
        repeat (10) begin                                    // Quiet bus while in reset
            @(negedge clk);
            check_value("awready", 32'(awready), 32'd0);
            check_value("wready", 32'(wready), 32'd0);
            check_value("arready", 32'(arready), 32'd0);
            check_value("bvalid", 32'(bvalid), 32'd0);
            check_value("rvalid", 32'(rvalid), 32'd0);
        end
        @(posedge clk);
        #1 arst_n = 1'b1;

        for (int i = 0; i < FILL_WORDS; i++) begin           // Known contents in the window
            a = 12'(i * 4);
            write_txn(a, {8'hC3, a, ~a}, 4'hF);
        end

        write_txn(12'h020, 32'hDEAD_BEEF, 4'hF);             // Full word and readback
        read_txn(12'h020, 1'b0);

        write_txn(12'h040, 32'hAAAA_AAAA, 4'b0001);          // Lane merge on one word
        write_txn(12'h040, 32'hBBBB_BBBB, 4'b0110);
        write_txn(12'h040, 32'hCCCC_CCCC, 4'b1000);
        read_txn(12'h040, 1'b0);

        write_txn(12'h010, 32'h5A5A_5A5A, 4'hF);
        write_txn(12'h810, 32'hFFFF_FFFF, 4'hF);             // Upper half alias of 0x010
        read_txn(12'h010, 1'b0);
        read_txn(12'h810, 1'b0);

        stall_en = 1'b1;
        fork
            repeat (RAND_EACH) begin
                repeat (next_random() % 3) @(posedge clk);
                write_txn(pick_addr(), next_random(), 4'(next_random()));
            end
            repeat (RAND_EACH) read_txn(12'h000, 1'b1);
        join

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
